//--- source/rnn_pkg.sv
`default_nettype none

package rnn_pkg;

	// --------------------------------------------------
	// sequencer states
	// --------------------------------------------------
	typedef enum logic [1:0] {
		st_idle,
		st_load,
		st_calc
	} ctrl_state_t;

	// --------------------------------------------------
	// network shape
	// --------------------------------------------------
	// vector length and matrix order
	localparam int N_DIM = 3;
	// time steps per sequence
	localparam int N_STEP = 3;
	// elements streamed per sequence
	localparam int N_ELEM = N_DIM * N_DIM;
	// hidden rows of all steps plus the trailing output rows
	localparam int CALC_CYCLES = N_STEP * N_DIM + N_DIM;

	// select widths
	localparam int IDX_W = 4;
	localparam int ROW_W = 2;

endpackage

`default_nettype wire

//--- source/rnn_mac_sat.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_mac_sat #(
	parameter int DATA_W  = 16,
	parameter int FRAC_W  = 8,
	parameter int N_TERMS = 3
) (
	input  logic signed [DATA_W-1:0] a_vec [N_TERMS],
	input  logic signed [DATA_W-1:0] b_vec [N_TERMS],
	output logic signed [DATA_W-1:0] acc
);

	localparam int PROD_W = 2 * DATA_W;
	// room for the carries of all terms
	localparam int SUM_W  = PROD_W + $clog2(N_TERMS) + 1;

	localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'({(DATA_W-1){1'b1}});
	localparam logic signed [SUM_W-1:0] SAT_MIN = -SAT_MAX - 1;

	logic signed [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] scaled;

	always_comb begin
		logic signed [PROD_W-1:0] prod;
		sum = '0;
		for (int i = 0; i < N_TERMS; i++) begin
			prod = a_vec[i] * b_vec[i];
			sum  = sum + prod;
		end
	end

	// drop the extra fraction bits, rounds toward minus infinity
	assign scaled = sum >>> FRAC_W;

	always_comb begin
		if (scaled > SAT_MAX) begin
			acc = SAT_MAX[DATA_W-1:0];
		end else if (scaled < SAT_MIN) begin
			acc = SAT_MIN[DATA_W-1:0];
		end else begin
			acc = scaled[DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- source/rnn_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_ctrl
	import rnn_pkg::*;
(
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	output logic             load_en,
	output logic [IDX_W-1:0] load_idx,
	output logic             start,
	output logic             hid_en,
	output logic [ROW_W-1:0] hid_step,
	output logic [ROW_W-1:0] hid_row,
	output logic             out_en,
	output logic [ROW_W-1:0] out_row
);

	ctrl_state_t      state_q;
	ctrl_state_t      state_nxt;
	logic [IDX_W-1:0] load_cnt;
	logic [IDX_W-1:0] load_nxt;
	logic [IDX_W-1:0] calc_cnt;
	logic [IDX_W-1:0] calc_nxt;
	logic             hid_nxt;
	logic             out_nxt;

	// --------------------------------------------------
	// next state and counters
	// --------------------------------------------------
	always_comb begin
		state_nxt = state_q;
		load_nxt  = load_cnt;
		calc_nxt  = calc_cnt;
		case (state_q)
			st_idle: begin
				// element 0 is written on this same edge
				if (in_valid) begin
					state_nxt = st_load;
					load_nxt  = IDX_W'(1);
				end
			end
			st_load: begin
				if (in_valid) begin
					if (load_cnt == IDX_W'(N_ELEM - 1)) begin
						state_nxt = st_calc;
						load_nxt  = '0;
						calc_nxt  = '0;
					end else begin
						load_nxt = load_cnt + IDX_W'(1);
					end
				end
			end
			st_calc: begin
				if (calc_cnt == IDX_W'(CALC_CYCLES - 1)) begin
					state_nxt = st_idle;
					calc_nxt  = '0;
				end else begin
					calc_nxt = calc_cnt + IDX_W'(1);
				end
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	// hidden rows first, output rows trail by one step
	assign hid_nxt = (state_nxt == st_calc) && (calc_nxt < IDX_W'(N_STEP * N_DIM));
	assign out_nxt = (state_nxt == st_calc) && (calc_nxt >= IDX_W'(N_DIM));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= st_idle;
			load_cnt <= '0;
			calc_cnt <= '0;
			hid_en   <= 1'b0;
			hid_step <= '0;
			hid_row  <= '0;
			out_en   <= 1'b0;
			out_row  <= '0;
		end else begin
			state_q  <= state_nxt;
			load_cnt <= load_nxt;
			calc_cnt <= calc_nxt;
			hid_en   <= hid_nxt;
			hid_step <= hid_nxt ? ROW_W'(calc_nxt / N_DIM) : '0;
			hid_row  <= hid_nxt ? ROW_W'(calc_nxt % N_DIM) : '0;
			out_en   <= out_nxt;
			out_row  <= out_nxt ? ROW_W'(calc_nxt % N_DIM) : '0;
		end
	end

	// --------------------------------------------------
	// load side follows in_valid directly
	// --------------------------------------------------
	assign load_en  = in_valid && (state_q != st_calc);
	assign load_idx = load_cnt;
	assign start    = in_valid && (state_q == st_idle);

endmodule

`default_nettype wire

//--- source/rnn_param_store.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_param_store
	import rnn_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_en,
	input  logic        [IDX_W-1:0]  load_idx,
	input  logic signed [DATA_W-1:0] data_x,
	input  logic signed [DATA_W-1:0] weight_u,
	input  logic signed [DATA_W-1:0] weight_w,
	input  logic signed [DATA_W-1:0] weight_v,
	input  logic        [ROW_W-1:0]  hid_step,
	input  logic        [ROW_W-1:0]  hid_row,
	input  logic        [ROW_W-1:0]  out_row,
	output logic signed [DATA_W-1:0] x_vec [N_DIM],
	output logic signed [DATA_W-1:0] u_row [N_DIM],
	output logic signed [DATA_W-1:0] w_row [N_DIM],
	output logic signed [DATA_W-1:0] v_row [N_DIM]
);

	// the binary point only matters downstream
	localparam int INT_W = DATA_W - FRAC_W;

	logic signed [DATA_W-1:0] x_mem [N_ELEM];
	logic signed [DATA_W-1:0] u_mem [N_ELEM];
	logic signed [DATA_W-1:0] w_mem [N_ELEM];
	logic signed [DATA_W-1:0] v_mem [N_ELEM];

	initial begin
		assert (INT_W >= 2)
		else $error("need at least two integer bits for the sigmoid range");
	end

	// --------------------------------------------------
	// write port, one element of each per valid cycle
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_ELEM; i++) begin
				x_mem[i] <= '0;
				u_mem[i] <= '0;
				w_mem[i] <= '0;
				v_mem[i] <= '0;
			end
		end else if (load_en) begin
			x_mem[load_idx] <= data_x;
			u_mem[load_idx] <= weight_u;
			w_mem[load_idx] <= weight_w;
			v_mem[load_idx] <= weight_v;
		end
	end

	// --------------------------------------------------
	// row reads
	// --------------------------------------------------
	// x is step major, matrices row major
	always_comb begin
		for (int i = 0; i < N_DIM; i++) begin
			x_vec[i] = x_mem[hid_step * N_DIM + i];
			u_row[i] = u_mem[hid_row * N_DIM + i];
			w_row[i] = w_mem[hid_row * N_DIM + i];
			v_row[i] = v_mem[out_row * N_DIM + i];
		end
	end

endmodule

`default_nettype wire

//--- source/rnn_hidden_cell.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_hidden_cell
	import rnn_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     hid_en,
	input  logic        [ROW_W-1:0]  hid_row,
	input  logic signed [DATA_W-1:0] u_row [N_DIM],
	input  logic signed [DATA_W-1:0] w_row [N_DIM],
	input  logic signed [DATA_W-1:0] x_vec [N_DIM],
	output logic signed [DATA_W-1:0] h_cur [N_DIM]
);

	// one extra bit keeps the sigmoid sum clear of overflow
	localparam logic signed [DATA_W:0] ONE =
		{{(DATA_W-FRAC_W){1'b0}}, 1'b1, {FRAC_W{1'b0}}};
	localparam logic signed [DATA_W:0] HALF = ONE >>> 1;

	logic signed [DATA_W-1:0] mac_a [2*N_DIM];
	logic signed [DATA_W-1:0] mac_b [2*N_DIM];
	logic signed [DATA_W-1:0] pre;
	logic signed [DATA_W:0]   sig_wide;
	logic signed [DATA_W-1:0] h_new;
	logic signed [DATA_W-1:0] h_next [N_DIM];

	// --------------------------------------------------
	// U row against x, W row against h(t-1)
	// --------------------------------------------------
	always_comb begin
		for (int i = 0; i < N_DIM; i++) begin
			mac_a[i]         = u_row[i];
			mac_b[i]         = x_vec[i];
			mac_a[N_DIM + i] = w_row[i];
			mac_b[N_DIM + i] = h_cur[i];
		end
	end

	rnn_mac_sat #(
		.DATA_W  (DATA_W),
		.FRAC_W  (FRAC_W),
		.N_TERMS (2 * N_DIM)
	) u_mac (
		.a_vec (mac_a),
		.b_vec (mac_b),
		.acc   (pre)
	);

	// hard sigmoid, pre/4 + 0.5 clamped to [0, 1]
	assign sig_wide = (pre >>> 2) + HALF;

	always_comb begin
		if (sig_wide < 0) begin
			h_new = '0;
		end else if (sig_wide > ONE) begin
			h_new = ONE[DATA_W-1:0];
		end else begin
			h_new = sig_wide[DATA_W-1:0];
		end
	end

	// --------------------------------------------------
	// state banks
	// --------------------------------------------------
	// rows collect in h_next, h_cur holds h(t-1) until the last row
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_DIM; i++) begin
				h_next[i] <= '0;
				h_cur[i]  <= '0;
			end
		end else if (start) begin
			for (int i = 0; i < N_DIM; i++) begin
				h_next[i] <= '0;
				h_cur[i]  <= '0;
			end
		end else if (hid_en) begin
			h_next[hid_row] <= h_new;
			if (hid_row == ROW_W'(N_DIM - 1)) begin
				for (int i = 0; i < N_DIM; i++) begin
					h_cur[i] <= (i == int'(hid_row)) ? h_new : h_next[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/rnn_output_stage.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_output_stage
	import rnn_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     out_en,
	input  logic        [ROW_W-1:0]  out_row,
	input  logic signed [DATA_W-1:0] v_row [N_DIM],
	input  logic signed [DATA_W-1:0] h_cur [N_DIM],
	output logic                     out_valid,
	output logic signed [DATA_W-1:0] out
);

	logic signed [DATA_W-1:0] y_pre;
	logic signed [DATA_W-1:0] y_relu;

	// V row against the committed state
	rnn_mac_sat #(
		.DATA_W  (DATA_W),
		.FRAC_W  (FRAC_W),
		.N_TERMS (N_DIM)
	) u_mac (
		.a_vec (v_row),
		.b_vec (h_cur),
		.acc   (y_pre)
	);

	assign y_relu = y_pre[DATA_W-1] ? '0 : y_pre;

	// --------------------------------------------------
	// output register
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out       <= '0;
		end else begin
			out_valid <= out_en;
			out       <= out_en ? y_relu : '0;
		end
	end

endmodule

`default_nettype wire

//--- source/rnn_top.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_top
	import rnn_pkg::*;
#(
	parameter int DATA_W = 16,
	parameter int FRAC_W = 8
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  logic signed [DATA_W-1:0] data_x,
	input  logic signed [DATA_W-1:0] weight_u,
	input  logic signed [DATA_W-1:0] weight_w,
	input  logic signed [DATA_W-1:0] weight_v,
	output logic                     out_valid,
	output logic signed [DATA_W-1:0] out
);

	// --------------------------------------------------
	// sequencer selects
	// --------------------------------------------------
	logic             load_en;
	logic [IDX_W-1:0] load_idx;
	logic             start;
	logic             hid_en;
	logic [ROW_W-1:0] hid_step;
	logic [ROW_W-1:0] hid_row;
	logic             out_en;
	logic [ROW_W-1:0] out_row;

	// datapath rows
	logic signed [DATA_W-1:0] x_vec [N_DIM];
	logic signed [DATA_W-1:0] u_row [N_DIM];
	logic signed [DATA_W-1:0] w_row [N_DIM];
	logic signed [DATA_W-1:0] v_row [N_DIM];
	logic signed [DATA_W-1:0] h_cur [N_DIM];

	rnn_ctrl u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.load_en  (load_en),
		.load_idx (load_idx),
		.start    (start),
		.hid_en   (hid_en),
		.hid_step (hid_step),
		.hid_row  (hid_row),
		.out_en   (out_en),
		.out_row  (out_row)
	);

	rnn_param_store #(
		.DATA_W (DATA_W),
		.FRAC_W (FRAC_W)
	) u_store (
		.clk      (clk),
		.rst_n    (rst_n),
		.load_en  (load_en),
		.load_idx (load_idx),
		.data_x   (data_x),
		.weight_u (weight_u),
		.weight_w (weight_w),
		.weight_v (weight_v),
		.hid_step (hid_step),
		.hid_row  (hid_row),
		.out_row  (out_row),
		.x_vec    (x_vec),
		.u_row    (u_row),
		.w_row    (w_row),
		.v_row    (v_row)
	);

	rnn_hidden_cell #(
		.DATA_W (DATA_W),
		.FRAC_W (FRAC_W)
	) u_hidden (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.hid_en  (hid_en),
		.hid_row (hid_row),
		.u_row   (u_row),
		.w_row   (w_row),
		.x_vec   (x_vec),
		.h_cur   (h_cur)
	);

	rnn_output_stage #(
		.DATA_W (DATA_W),
		.FRAC_W (FRAC_W)
	) u_output (
		.clk       (clk),
		.rst_n     (rst_n),
		.out_en    (out_en),
		.out_row   (out_row),
		.v_row     (v_row),
		.h_cur     (h_cur),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

`default_nettype wire

//--- tests/rnn_tb_props.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_tb_props #(
	parameter int DATA_W = 16
) (
	input wire                     clk,
	input wire                     rst_n,
	input wire                     in_valid,
	input wire                     out_valid,
	input wire signed [DATA_W-1:0] out
);

	// quiet output in reset and in the first cycle out of it
	reset_quiet: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !out_valid)
	else $error("out_valid high during or right after reset");

	// nine results per sequence, back to back
	burst_len: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> out_valid [*9] ##1 !out_valid)
	else $error("out_valid burst is not nine cycles long");

	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && in_valid))
	else $error("in_valid and out_valid high together");

	// ReLU keeps results non-negative
	relu_sign: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !out[DATA_W-1])
	else $error("negative result on out");

endmodule

bind rnn_top rnn_tb_props #(
	.DATA_W (DATA_W)
) u_props (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out       (out)
);

`default_nettype wire

//--- tests/rnn_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rnn_tb
	import rnn_pkg::*;
;

	localparam int DATA_W = 16;
	localparam int FRAC_W = 8;
	// first out_valid seen this many cycles after the last in_valid
	localparam int OUT_LAT = 5;
	localparam int N_SEQ = 9;
	localparam int CYCLE_LIMIT = 30 * N_SEQ + 100;
	localparam int COLLECT_MAX = 40;
	localparam longint ONE = longint'(1) << FRAC_W;
	localparam longint HALF = ONE >>> 1;
	localparam longint MAX_V = (longint'(1) << (DATA_W - 1)) - 1;
	localparam longint MIN_V = -MAX_V - 1;

	logic                     clk;
	logic                     rst_n;
	logic                     in_valid;
	logic signed [DATA_W-1:0] data_x;
	logic signed [DATA_W-1:0] weight_u;
	logic signed [DATA_W-1:0] weight_w;
	logic signed [DATA_W-1:0] weight_v;
	wire                      out_valid;
	wire signed [DATA_W-1:0]  out;

	// stimulus, expected and captured values of one sequence
	logic signed [DATA_W-1:0] sx [N_ELEM];
	logic signed [DATA_W-1:0] su [N_ELEM];
	logic signed [DATA_W-1:0] sw [N_ELEM];
	logic signed [DATA_W-1:0] sv [N_ELEM];
	longint                   exp_y [N_ELEM];
	logic signed [DATA_W-1:0] got_y [N_ELEM];

	logic [31:0] lfsr_state;
	int          checks;
	int          errors;
	int          test_err_start;
	int          cycle_cnt;

	rnn_top #(
		.DATA_W (DATA_W),
		.FRAC_W (FRAC_W)
	) u_rnn_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.data_x    (data_x),
		.weight_u  (weight_u),
		.weight_w  (weight_w),
		.weight_v  (weight_v),
		.out_valid (out_valid),
		.out       (out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the DUT did not finish", cycle_cnt);
		$display("TB FAILED");
		$finish;
	end

	// --------------------------------------------------
	// random numbers
	// --------------------------------------------------
	function automatic logic lfsr_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (lsb) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return lsb;
	endfunction

	function automatic longint rand_bits(input int n);
		longint v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | longint'(lfsr_bit());
		end
		return v;
	endfunction

	// about plus or minus one in fixed point
	function automatic longint rand_small();
		longint v;
		v = rand_bits(FRAC_W + 1);
		if (v >= (longint'(1) << FRAC_W)) begin
			v = v - (longint'(1) << (FRAC_W + 1));
		end
		return v;
	endfunction

	// --------------------------------------------------
	// reference model
	// --------------------------------------------------
	function automatic longint scale_sat(input longint sum);
		longint s;
		s = sum >>> FRAC_W;
		if (s > MAX_V) begin
			s = MAX_V;
		end else if (s < MIN_V) begin
			s = MIN_V;
		end
		return s;
	endfunction

	function automatic longint hard_sigmoid(input longint pre);
		longint s;
		s = (pre >>> 2) + HALF;
		if (s < 0) begin
			s = 0;
		end else if (s > ONE) begin
			s = ONE;
		end
		return s;
	endfunction

	function automatic void run_model();
		longint h [N_DIM];
		longint h_new [N_DIM];
		longint sum;
		longint y;
		for (int i = 0; i < N_DIM; i++) begin
			h[i] = 0;
		end
		for (int t = 0; t < N_STEP; t++) begin
			for (int r = 0; r < N_DIM; r++) begin
				sum = 0;
				for (int i = 0; i < N_DIM; i++) begin
					sum += longint'(su[r*N_DIM+i]) * longint'(sx[t*N_DIM+i]);
					sum += longint'(sw[r*N_DIM+i]) * h[i];
				end
				h_new[r] = hard_sigmoid(scale_sat(sum));
			end
			h = h_new;
			for (int r = 0; r < N_DIM; r++) begin
				sum = 0;
				for (int i = 0; i < N_DIM; i++) begin
					sum += longint'(sv[r*N_DIM+i]) * h[i];
				end
				y = scale_sat(sum);
				exp_y[t*N_DIM+r] = (y < 0) ? 0 : y;
			end
		end
	endfunction

	// --------------------------------------------------
	// checks and reporting
	// --------------------------------------------------
	task automatic compare_data(input string name, input logic signed [DATA_W-1:0] expected,
		input logic signed [DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic compare_count(input string name, input integer expected, input integer actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic report_test(input string name);
		if (errors == test_err_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - test_err_start);
		end
		test_err_start = errors;
	endtask

	// --------------------------------------------------
	// sequence driving, all on the falling edge
	// --------------------------------------------------
	task automatic load_seq();
		for (int k = 0; k < N_ELEM; k++) begin
			in_valid = 1'b1;
			data_x   = sx[k];
			weight_u = su[k];
			weight_w = sw[k];
			weight_v = sv[k];
			@(negedge clk);
		end
		in_valid = 1'b0;
		data_x   = '0;
		weight_u = '0;
		weight_w = '0;
		weight_v = '0;
	endtask

	// returns on the first falling edge after the burst
	task automatic collect_seq(output int n_valid, output int first_lat);
		int lat;
		bit done;
		lat       = 1;
		n_valid   = 0;
		first_lat = -1;
		done      = 1'b0;
		for (int k = 0; k < N_ELEM; k++) begin
			got_y[k] = '0;
		end
		while (!done) begin
			if (out_valid) begin
				if (first_lat < 0) begin
					first_lat = lat;
				end
				if (n_valid < N_ELEM) begin
					got_y[n_valid] = out;
				end
				n_valid++;
			end else if (n_valid > 0 || lat > COLLECT_MAX) begin
				done = 1'b1;
			end
			if (!done) begin
				@(negedge clk);
				lat++;
			end
		end
	endtask

	task automatic run_seq(input string name);
		int n_valid;
		int first_lat;
		run_model();
		load_seq();
		collect_seq(n_valid, first_lat);
		if (first_lat < 0) begin
			$display("%s: out_valid never rose after the load", name);
		end
		compare_count({name, " valid count"}, N_ELEM, n_valid);
		compare_count({name, " latency"}, OUT_LAT, first_lat);
		for (int k = 0; k < N_ELEM; k++) begin
			compare_data($sformatf("%s y[%0d]", name, k), exp_y[k], got_y[k]);
		end
	endtask

	task automatic fill_random();
		for (int k = 0; k < N_ELEM; k++) begin
			sx[k] = rand_small();
			su[k] = rand_small();
			sw[k] = rand_small();
			sv[k] = rand_small();
			if (sw[k] == 0) begin
				sw[k] = 1;
			end
		end
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------
	task automatic reset_idle();
		for (int c = 0; c < 6; c++) begin
			compare_count("reset_idle out_valid", 0, out_valid);
			compare_data("reset_idle out", '0, out);
			@(negedge clk);
		end
		report_test("reset_idle");
	endtask

	// h stays at one half for every step
	task automatic half_hidden();
		fill_random();
		for (int k = 0; k < N_ELEM; k++) begin
			su[k] = '0;
			sw[k] = '0;
		end
		run_seq("half_hidden");
		report_test("half_hidden");
	endtask

	task automatic relu_clamp();
		fill_random();
		for (int k = 0; k < N_ELEM; k++) begin
			sv[k] = -(rand_bits(FRAC_W) + 1);
		end
		run_seq("relu_clamp");
		report_test("relu_clamp");
	endtask

	task automatic sigmoid_saturate();
		for (int k = 0; k < N_ELEM; k++) begin
			sx[k] = ONE;
			su[k] = MAX_V;
			sw[k] = '0;
		end
		// row sums saturate, stay moderate, and go negative
		for (int i = 0; i < N_DIM; i++) begin
			sv[i]           = 20000;
			sv[N_DIM + i]   = 100 * (i + 1);
			sv[2*N_DIM + i] = (i == 0) ? -50 : 20;
		end
		run_seq("sigmoid_saturate");
		report_test("sigmoid_saturate");
	endtask

	task automatic random_recurrence();
		for (int s = 0; s < 4; s++) begin
			fill_random();
			run_seq($sformatf("random_recurrence %0d", s));
		end
		report_test("random_recurrence");
	endtask

	task automatic back_to_back();
		fill_random();
		run_seq("back_to_back first");
		fill_random();
		run_seq("back_to_back second");
		report_test("back_to_back");
	endtask

	initial begin
		lfsr_state     = 32'h1a87;
		checks         = 0;
		errors         = 0;
		test_err_start = 0;
		rst_n          = 1'b1;
		in_valid       = 1'b0;
		data_x         = '0;
		weight_u       = '0;
		weight_w       = '0;
		weight_v       = '0;
		#1 rst_n = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		reset_idle();
		half_hidden();
		relu_clamp();
		sigmoid_saturate();
		random_recurrence();
		back_to_back();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
source/rnn_pkg.sv
source/rnn_mac_sat.sv
source/rnn_ctrl.sv
source/rnn_param_store.sv
source/rnn_hidden_cell.sv
source/rnn_output_stage.sv
source/rnn_top.sv
tests/rnn_tb_props.sv
tests/rnn_tb.sv

//--- Bender.yml
package:
  name: rnn_cell

sources:
  - files:
      - source/rnn_pkg.sv
      - source/rnn_mac_sat.sv
      - source/rnn_ctrl.sv
      - source/rnn_param_store.sv
      - source/rnn_hidden_cell.sv
      - source/rnn_output_stage.sv
      - source/rnn_top.sv
  - target: test
    files:
      - tests/rnn_tb_props.sv
      - tests/rnn_tb.sv
